// File: design/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and constants
    //////////////////////////////////////////////////////////////////////

    localparam int xlen = 32;                          // data and address width
    localparam int id_w = 4;                           // read channel id width

    localparam logic [id_w-1:0] fetch_id  = id_w'(1);  // id carried by every fetch request
    localparam logic [xlen-1:0] inst_step = xlen'(4);  // no compressed instructions

    //////////////////////////////////////////////////////////////////////
    // state encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        idle     = 2'd0,
        req      = 2'd1,                               // ar_valid is up in this state
        wait_rsp = 2'd2,
        done     = 2'd3                                // one cycle, word goes to decode
    } fetch_state_t;

    typedef enum logic [1:0] {
        md_idle  = 2'd0,
        md_busy  = 2'd1,                               // mul/div still running
        md_drain = 2'd2                                // op finished, older fetch still out
    } md_state_t;

endpackage

// File: design/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [xlen-1:0] pc,
    input  logic            mem_busy,
    input  logic            hold,
    input  logic            redirect,
    input  logic            jalr,
    output logic            ar_valid,
    output logic [xlen-1:0] ar_addr,
    output logic [id_w-1:0] ar_id,
    input  logic            ar_ready,
    input  logic            r_valid,
    input  logic [id_w-1:0] r_id,
    input  logic [xlen-1:0] r_data,
    output logic            inst_valid,
    output logic [xlen-1:0] inst,
    output logic [xlen-1:0] inst_pc,
    output logic            fetch_done,
    output logic            fetch_busy
);

    fetch_state_t    state;
    fetch_state_t    state_nxt;
    logic            go;
    logic            rsp_hit;
    logic            flush;
    logic            jalr_q;
    logic [xlen-1:0] addr_q;
    logic [xlen-1:0] inst_q;

    assign go      = !mem_busy && !hold;
    assign rsp_hit = r_valid && (r_id == fetch_id);    // foreign ids are simply ignored

    //////////////////////////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            idle:     if (go) state_nxt = req;
            req:      if (ar_ready) state_nxt = wait_rsp;
            wait_rsp: if (rsp_hit) state_nxt = done;
            done:     state_nxt = idle;
            default:  state_nxt = idle;
        endcase
    end

    // A fetch started in the same cycle as a redirect, or while a jalr target is
    // still on its way into the pc, was issued for a stale address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flush  <= 1'b0;
            jalr_q <= 1'b0;
        end else begin
            jalr_q <= jalr;
            case (state)
                idle:          flush <= go && (redirect || jalr || jalr_q);
                req, wait_rsp: flush <= flush || redirect || jalr;
                default:       flush <= flush;    // word in done is already committed
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && go) begin
            addr_q <= pc;                              // request address, held until next fetch
        end
        if (state == wait_rsp && rsp_hit) begin
            inst_q <= r_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    assign ar_valid   = (state == req);
    assign ar_addr    = addr_q;
    assign ar_id      = ar_valid ? fetch_id : '0;

    assign inst_valid = (state == done) && !flush;     // flushed words are consumed silently
    assign inst       = inst_q;
    assign inst_pc    = addr_q;

    assign fetch_done = (state == wait_rsp) && rsp_hit && !flush;
    assign fetch_busy = (state != idle);

endmodule

// File: design/pc_gen.sv
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    input  logic            jalr,
    input  logic            mem_busy,
    input  logic            fetch_done,
    output logic [xlen-1:0] pc
);

    typedef enum logic [2:0] {
        sel_keep     = 3'd0,
        sel_redirect = 3'd1,
        sel_target   = 3'd2,
        sel_step     = 3'd3,
        sel_busy     = 3'd4
    } pc_sel_t;

    pc_sel_t         pc_sel;
    logic            jalr_q;
    logic [xlen-1:0] pc_step;
    logic [xlen-1:0] pc_nxt;

    assign pc_step = pc + inst_step;

    //////////////////////////////////////////////////////////////////////
    // next-pc priority
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (redirect) begin
            pc_sel = sel_redirect;
        end else if (jalr) begin
            pc_sel = sel_keep;                         // register target shows up one cycle later
        end else if (jalr_q) begin
            pc_sel = sel_target;
        end else if (fetch_done) begin
            pc_sel = sel_step;
        end else if (mem_busy) begin
            pc_sel = sel_busy;
        end else begin
            pc_sel = sel_keep;                         // idle, or held by a mul/div op
        end
    end

    always_comb begin
        case (pc_sel)
            sel_redirect: pc_nxt = redirect_pc;
            sel_target:   pc_nxt = redirect_pc;
            sel_step:     pc_nxt = pc_step;
            default:      pc_nxt = pc;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jalr_q <= 1'b0;
        end else begin
            jalr_q <= jalr && !redirect;               // a same-cycle redirect already won
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_nxt;
        end
    end

endmodule

// File: design/md_stall.sv
`timescale 1ns/1ps

module md_stall import fetch_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic md_start,
    input  logic md_done,
    input  logic fetch_busy,
    output logic hold
);

    md_state_t state;
    md_state_t state_nxt;

    //////////////////////////////////////////////////////////////////////
    // tracker
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= md_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            md_idle: begin
                if (md_start) begin
                    state_nxt = md_busy;
                end
            end
            md_busy: begin
                if (md_done && fetch_busy) begin
                    state_nxt = md_drain;              // let the older fetch land first
                end else if (md_done) begin
                    state_nxt = md_idle;
                end
            end
            md_drain: begin
                if (!fetch_busy) begin
                    state_nxt = md_idle;
                end
            end
            default: state_nxt = md_idle;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // hold level
    //////////////////////////////////////////////////////////////////////

    // registered so fetch_ctrl sees a clean level starting the cycle after md_start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold <= 1'b0;
        end else begin
            hold <= (state_nxt != md_idle);
        end
    end

endmodule

// File: design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    input  logic            jalr,
    input  logic            mem_busy,
    input  logic            md_start,
    input  logic            md_done,
    output logic            ar_valid,
    output logic [xlen-1:0] ar_addr,
    output logic [id_w-1:0] ar_id,
    input  logic            ar_ready,
    input  logic            r_valid,
    input  logic [id_w-1:0] r_id,
    input  logic [xlen-1:0] r_data,
    output logic            inst_valid,
    output logic [xlen-1:0] inst,
    output logic [xlen-1:0] inst_pc
);

    logic [xlen-1:0] pc;
    logic            hold;
    logic            fetch_done;
    logic            fetch_busy;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    fetch_ctrl u_fetch_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc         (pc),
        .mem_busy   (mem_busy),
        .hold       (hold),
        .redirect   (redirect),
        .jalr       (jalr),
        .ar_valid   (ar_valid),
        .ar_addr    (ar_addr),
        .ar_id      (ar_id),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r_id       (r_id),
        .r_data     (r_data),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .fetch_done (fetch_done),
        .fetch_busy (fetch_busy)
    );

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    pc_gen #(
        .reset_pc (reset_pc)
    ) u_pc_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .jalr        (jalr),
        .mem_busy    (mem_busy),
        .fetch_done  (fetch_done),
        .pc          (pc)
    );

    md_stall u_md_stall (
        .clk        (clk),
        .rst_n      (rst_n),
        .md_start   (md_start),
        .md_done    (md_done),
        .fetch_busy (fetch_busy),
        .hold       (hold)
    );

endmodule

// File: sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                         // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: sim/fetch_properties.sv
`timescale 1ns/1ps

module fetch_properties import fetch_pkg::*; (
    input logic            clk,
    input logic            rst_n,
    input logic            ar_valid,
    input logic            ar_ready,
    input logic            hold,
    input logic [xlen-1:0] ar_addr,
    input logic [id_w-1:0] ar_id,
    input fetch_state_t    state
);

    int fail_count = 0;

    assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_id))
        else begin
            fail_count++;
            $error("read request changed or dropped before it was accepted");
        end

    // a request may only start from a cycle where hold was low
    assert property (@(posedge clk) disable iff (!rst_n) state == idle && hold |=> !ar_valid)
        else begin
            fail_count++;
            $error("read request raised while the mul/div hold was active");
        end

endmodule

bind fetch_ctrl fetch_properties props (.*);

// File: sim/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker import fetch_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            finished,
    input  int              test_id,
    input  logic            md_start,
    input  logic            md_done,
    input  logic            ar_valid,
    input  logic [xlen-1:0] ar_addr,
    input  logic [id_w-1:0] ar_id,
    input  logic            inst_valid,
    input  logic [xlen-1:0] inst,
    input  logic [xlen-1:0] inst_pc,
    input  logic [xlen-1:0] exp_pc,
    input  logic [xlen-1:0] exp_inst,
    output int              errors,
    output int              tests_run,
    output int              tests_failed
);

    int   cur_test  = 1;
    int   test_errs = 0;
    bit   closed    = 1'b0;
    bit   first_req = 1'b1;                            // no request seen since reset
    logic av_q      = 1'b0;
    logic win       = 1'b0;                            // mul/div op between start and done
    logic win_q     = 1'b0;

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
    end

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset and first fetch";
            2:       return "sequential fetches";
            3:       return "redirect";
            4:       return "jalr";
            5:       return "mul/div stall";
            default: return "foreign ids and memory busy";
        endcase
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Fail %0t: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // comparison
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst_n && (ar_valid || inst_valid)) report_mismatch("output active during reset");
        if (rst_n && ar_valid && first_req) begin
            if (ar_addr !== reset_pc)
                report_mismatch($sformatf("first ar_addr %h, expected %h", ar_addr, reset_pc));
            first_req = 1'b0;
        end
        if (inst_valid && inst_pc !== exp_pc)
            report_mismatch($sformatf("inst_pc %h, expected %h", inst_pc, exp_pc));
        if (inst_valid && inst !== exp_inst)
            report_mismatch($sformatf("inst %h at %h, expected %h", inst, inst_pc, exp_inst));
        if (ar_valid && ar_id !== fetch_id) report_mismatch($sformatf("ar_id %h", ar_id));
        if (ar_valid && !av_q && win_q) report_mismatch("new request while mul/div op runs");
        av_q  <= ar_valid;
        win_q <= win;
        if (md_start) win <= 1'b1;
        else if (md_done) win <= 1'b0;
        if (!closed && (test_id != cur_test || finished)) begin
            tests_run++;
            if (test_errs != 0) tests_failed++;
            $display("test %0d %s: %s, %0d errors", cur_test, test_name(cur_test),
                     test_errs == 0 ? "ok" : "FAILED", test_errs);
            test_errs = 0;
            closed    = finished;
        end
        cur_test = test_id;
    end

endmodule

// File: sim/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*;;

    parameter logic [xlen-1:0] reset_pc = 32'h8000_0000;
    localparam int fetch_total  = 95;
    localparam int worst_cycles = 24;                  // slowest fetch plus event and md overhead
    localparam int timeout_ns   = (fetch_total * worst_cycles + 200) * 8;

    logic clk, rst_n;
    logic redirect, jalr, mem_busy, md_start, md_done;
    logic [xlen-1:0] redirect_pc, ar_addr, r_data, inst, inst_pc, exp_pc, exp_inst;
    logic ar_valid, ar_ready, r_valid, inst_valid, finished;
    logic [id_w-1:0] ar_id, r_id;
    int test_id, errors, tests_run, tests_failed, total;
    logic [31:0] rng = 32'h61cc268e;

    // the next presented pc is last_pc + 4 unless a target is pending
    logic [xlen-1:0] last_pc   = '0;
    logic [xlen-1:0] tgt       = reset_pc;
    logic            tgt_valid = 1'b1;
    logic            jalr_seen = 1'b0;

    logic [xlen-1:0] pend_addr;
    bit pending = 0, armed = 0, foreign = 0;
    int ready_wait, rsp_wait;

    clock_gen clkgen (.*);
    fetch_top #(.reset_pc(reset_pc)) dut (.*);
    fetch_checker #(.reset_pc(reset_pc)) chk (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [xlen-1:0] next_fetch_pc(input logic [xlen-1:0] last,
                                                      input logic tv, input logic [xlen-1:0] t);
        return tv ? t : last + inst_step;
    endfunction

    assign exp_pc   = next_fetch_pc(last_pc, tgt_valid, tgt);
    assign exp_inst = xorshift(exp_pc);                // the responder's word for that address

    always @(posedge clk) begin
        if (inst_valid) begin
            last_pc   <= exp_pc;
            tgt_valid <= 1'b0;
        end
        if (redirect || jalr_seen) begin               // jalr target is on redirect_pc a cycle later
            tgt_valid <= 1'b1;
            tgt       <= redirect_pc;
        end
        jalr_seen <= jalr && !redirect;
    end

    //////////////////////////////////////////////////////////////////////
    // memory responder
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        rng = xorshift(rng);
        r_valid  <= 1'b0;
        mem_busy <= (test_id == 6) && (rng[7:6] == 2'b00);
        if (ar_valid && ar_ready) begin
            ar_ready <= 1'b0;
            armed     = 0;
            pending   = 1;
            pend_addr = ar_addr;
            rsp_wait  = rng[1:0];
            foreign   = (test_id == 6) || (rng[3:2] == 2'b00);
        end else if (ar_valid && !ar_ready) begin
            if (!armed) begin
                armed      = 1;
                ready_wait = rng[5:4];
            end
            if (ready_wait == 0) ar_ready <= 1'b1;
            else ready_wait--;
        end else if (pending) begin
            if (rsp_wait > 0) begin
                rsp_wait--;
            end else begin
                r_valid <= 1'b1;
                r_id    <= foreign ? 4'h9 : fetch_id;
                r_data  <= xorshift(foreign ? ~pend_addr : pend_addr);
                pending  = foreign;                    // the real word follows a foreign one
                foreign  = 0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic wait_fetches(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk);
            if (inst_valid) seen++;
        end
    endtask

    task automatic send_event(input int kind);
        @(posedge clk);
        rng = xorshift(rng);
        redirect    <= (kind == 3);
        jalr        <= (kind == 4);
        md_start    <= (kind == 5);
        redirect_pc <= {rng[31:2], 2'b00};
        @(posedge clk);
        rng = xorshift(rng);
        redirect    <= 1'b0;
        jalr        <= 1'b0;
        md_start    <= 1'b0;
        redirect_pc <= {rng[31:2], 2'b00};
        if (kind == 5) begin
            repeat (4 + rng[2:0]) @(posedge clk);
            md_done <= 1'b1;
            @(posedge clk);
            md_done <= 1'b0;
        end
    endtask

    initial begin
        {redirect, jalr, mem_busy, md_start, md_done, ar_ready, r_valid, finished} = '0;
        redirect_pc = '0;
        r_id        = '0;
        r_data      = '0;
        test_id     = 1;
        @(posedge rst_n);
        wait_fetches(1);
        test_id <= 2;
        wait_fetches(20);
        for (int t = 3; t <= 5; t++) begin
            test_id <= t;
            repeat (6) begin
                repeat (rng[4:2]) @(posedge clk);
                send_event(t);
                wait_fetches(3);
            end
        end
        test_id <= 6;
        wait_fetches(20);
        finished <= 1'b1;
        repeat (2) @(posedge clk);
        total = errors + dut.u_fetch_ctrl.props.fail_count;
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, total);
        if (total == 0 && tests_failed == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: the fetch unit stopped presenting instructions");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: build.f
design/fetch_pkg.sv
design/fetch_ctrl.sv
design/pc_gen.sv
design/md_stall.sv
design/fetch_top.sv
sim/clock_gen.sv
sim/fetch_properties.sv
sim/fetch_checker.sv
sim/tb_fetch_top.sv
